//--- project.f
+incdir+tb
src/soc_pkg.sv
src/soc_reset_gen.sv
src/wb_addr_decode.sv
src/wb_bram.sv
src/wb_csr_bridge.sv
src/sysctl_csr.sv
src/wb_response_mux.sv
src/soc_top.sv
tb/tb_soc_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the soc_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f project.f \
	--top-module tb_soc_top \
	-o tb_soc_top_sim

./obj_dir/tb_soc_top_sim

//--- tb/tb_soc_model.svh
// reference model for the soc bus backbone testbench
// ram shadow, expected csr state, the lcg and expected-value helpers
// included inside the testbench top module

`ifndef TB_SOC_MODEL_SVH
`define TB_SOC_MODEL_SVH

// shadow of the block ram plus the register state the controller should hold
logic [WB_DATA_W-1:0] ram_shadow [2**RAM_ADDR_W];
logic                 model_led;
logic                 model_err_en;
logic [N_BUTTONS-1:0] model_pending;
logic [N_BUTTONS-1:0] model_btn;
logic [31:0]          lcg_state;

// numerical recipes constants
function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// byte-lane merge as a wishbone write should land
function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] sel);
	logic [31:0] result;
	result = old_word;
	for (int i = 0; i < 4; i++) begin
		if (sel[i]) begin
			result[8*i +: 8] = new_word[8*i +: 8];
		end
	end
	return result;
endfunction

// expected read value of a csr, other banks read zero
function automatic logic [31:0] expected_csr(input logic [3:0] bank, input logic [7:0] idx);
	if (bank != SYSCTL_BANK) begin
		return 32'd0;
	end
	case (idx)
		REG_GPIO_IN: return {29'd0, model_btn};
		REG_GPIO_OUT: return {31'd0, model_led};
		REG_IRQ_PENDING: return {29'd0, model_pending};
		REG_CONTROL: return {31'd0, model_err_en};
		REG_CAPABILITIES: return SYSCTL_CAPABILITIES;
		REG_SYSTEM_ID: return SYSCTL_SYSTEM_ID;
		default: return 32'd0;
	endcase
endfunction

// err for a ram access, null page is words 0..1023
function automatic logic expected_ram_err(input logic [10:0] word);
	return model_err_en && (word < 11'd1024);
endfunction

`endif

//--- tb/tb_soc_top.sv
// testbench for soc_top
// acts as the single wishbone master and checks ram, csr, irq,
// bus errors and the reset sources against the model in tb_soc_model.svh

`timescale 1ns/100ps

module tb_soc_top
	import soc_pkg::*;
;

	localparam int N_RAM = 16;
	// ram loop about 9 cycles per word, csr and reset phases on top
	localparam int TEST_CYCLES = N_RAM * 9 + 40 * 6 + 4 * (RST_HOLD_CYCLES + 20);
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;
	localparam int ACK_LIMIT = 20;

	logic                 sys_clk;
	logic                 trigger_reset;
	logic [WB_ADDR_W-1:0] wb_adr;
	logic [WB_DATA_W-1:0] wb_dat_w;
	logic [WB_SEL_W-1:0]  wb_sel;
	logic                 wb_we;
	logic                 wb_cyc;
	logic                 wb_stb;
	logic [WB_DATA_W-1:0] wb_dat_r;
	logic                 wb_ack;
	logic                 wb_err;
	logic [N_BUTTONS-1:0] btn;
	logic                 led;
	logic                 irq;
	int                   cycle_count = 0;

	`include "tb_soc_model.svh"

	soc_top uut (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.wb_adr_i      (wb_adr),
		.wb_dat_i      (wb_dat_w),
		.wb_sel_i      (wb_sel),
		.wb_we_i       (wb_we),
		.wb_cyc_i      (wb_cyc),
		.wb_stb_i      (wb_stb),
		.wb_dat_o      (wb_dat_r),
		.wb_ack_o      (wb_ack),
		.wb_err_o      (wb_err),
		.btn_i         (btn),
		.led_o         (led),
		.irq_o         (irq)
	);

	always #4 sys_clk = ~sys_clk;

	// ------------------------------
	// failure reporting
	// ------------------------------
	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			stop_on_error($sformatf("mismatch %s expected %h actual %h",
				name, expected, actual));
		end
	endtask

	// run watchdog
	always @(posedge sys_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			stop_on_error($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
		end
	end

	// ------------------------------
	// bus master
	// ------------------------------
	// called 1 ns after an edge, returns 1 ns after the idle cycle
	task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] dat,
			input logic [3:0] sel, output logic [31:0] rdata, output logic err,
			output int latency);
		latency = 0;
		wb_adr = adr;
		wb_dat_w = dat;
		wb_sel = sel;
		wb_we = we;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		do begin
			@(posedge sys_clk);
			#1;
			latency++;
			if (latency > ACK_LIMIT) begin
				stop_on_error($sformatf("no ack from the bus for address %h", adr));
			end
		end while (!wb_ack);
		rdata = wb_dat_r;
		err = wb_err;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		// stb low for one cycle between requests
		@(posedge sys_clk);
		#1;
	endtask

	function automatic logic [31:0] ram_addr(input logic msb, input logic [10:0] word);
		return {msb, 3'd0, 15'd0, word, 2'b00};
	endfunction

	function automatic logic [31:0] csr_addr(input logic [3:0] bank, input logic [7:0] idx);
		return {1'b0, 3'd6, 14'd0, bank, idx, 2'b00};
	endfunction

	task automatic ram_write(input string name, input logic msb, input logic [10:0] word,
			input logic [31:0] dat, input logic [3:0] sel);
		logic [31:0] rdata;
		logic        err;
		int          lat;
		bus_cycle(1'b1, ram_addr(msb, word), dat, sel, rdata, err, lat);
		check_value({name, " err"}, {31'd0, expected_ram_err(word)}, {31'd0, err});
		check_value({name, " latency"}, 32'd1, lat);
		ram_shadow[word] = merge_bytes(ram_shadow[word], dat, sel);
	endtask

	task automatic ram_read(input string name, input logic msb, input logic [10:0] word);
		logic [31:0] rdata;
		logic        err;
		int          lat;
		bus_cycle(1'b0, ram_addr(msb, word), 32'd0, 4'hf, rdata, err, lat);
		check_value({name, " err"}, {31'd0, expected_ram_err(word)}, {31'd0, err});
		check_value({name, " latency"}, 32'd1, lat);
		check_value(name, ram_shadow[word], rdata);
	endtask

	task automatic csr_write(input logic [3:0] bank, input logic [7:0] idx,
			input logic [31:0] dat);
		logic [31:0] rdata;
		logic        err;
		int          lat;
		bus_cycle(1'b1, csr_addr(bank, idx), dat, 4'hf, rdata, err, lat);
		check_value("csr write latency", 32'd2, lat);
		check_value("csr write err", 32'd0, {31'd0, err});
	endtask

	task automatic csr_read(input string name, input logic [3:0] bank, input logic [7:0] idx);
		logic [31:0] rdata;
		logic        err;
		int          lat;
		bus_cycle(1'b0, csr_addr(bank, idx), 32'd0, 4'hf, rdata, err, lat);
		check_value({name, " latency"}, 32'd3, lat);
		check_value(name, expected_csr(bank, idx), rdata);
	endtask

	task automatic clear_model();
		model_led = 1'b0;
		model_err_en = 1'b0;
		model_pending = '0;
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		logic [10:0] words [N_RAM];
		logic [31:0] rdata;
		logic        err;
		int          lat;
		sys_clk = 1'b0;
		trigger_reset = 1'b1;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_sel = '0;
		wb_we = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		btn = '0;
		lcg_state = 32'd67;
		model_btn = '0;
		clear_model();
		repeat (10) @(posedge sys_clk);
		#1;
		trigger_reset = 1'b0;
		repeat (RST_HOLD_CYCLES + 4) @(posedge sys_clk);
		#1;

		// ram, above the null page, shadow alias through bit 31
		for (int i = 0; i < N_RAM; i++) begin
			words[i] = 11'd1024 + 11'(lcg_next() >> 22);
			ram_write("ram init", 1'(lcg_next() >> 31), words[i], lcg_next(), 4'hf);
			ram_write("ram bytes", 1'(lcg_next() >> 31), words[i], lcg_next(),
				4'(lcg_next() >> 28));
		end
		for (int i = 0; i < N_RAM; i++) begin
			ram_read("ram readback", 1'b0, words[i]);
			ram_read("ram shadow readback", 1'b1, words[i]);
		end

		// csr access and identification
		csr_write(SYSCTL_BANK, REG_GPIO_OUT, 32'd1);
		model_led = 1'b1;
		check_value("led after write", 32'd1, {31'd0, led});
		csr_read("gpio out", SYSCTL_BANK, REG_GPIO_OUT);
		csr_read("system id", SYSCTL_BANK, REG_SYSTEM_ID);
		csr_read("capabilities", SYSCTL_BANK, REG_CAPABILITIES);
		csr_read("other bank id", 4'd2, REG_SYSTEM_ID);
		csr_read("other bank gpio", 4'd0, REG_GPIO_OUT);

		// button change interrupt
		btn = 3'b001;
		model_btn = 3'b001;
		model_pending = 3'b001;
		repeat (5) @(posedge sys_clk);
		#1;
		check_value("irq after button", 32'd1, {31'd0, irq});
		csr_read("gpio in", SYSCTL_BANK, REG_GPIO_IN);
		csr_read("irq pending", SYSCTL_BANK, REG_IRQ_PENDING);
		csr_write(SYSCTL_BANK, REG_IRQ_PENDING, 32'd1);
		model_pending = '0;
		csr_read("irq pending cleared", SYSCTL_BANK, REG_IRQ_PENDING);
		check_value("irq after clear", 32'd0, {31'd0, irq});

		// bus errors
		bus_cycle(1'b0, {1'b0, 3'd2, 28'h0000100}, 32'd0, 4'hf, rdata, err, lat);
		check_value("unmapped err", 32'd1, {31'd0, err});
		check_value("unmapped latency", 32'd1, lat);
		ram_write("null page write", 1'b0, 11'd5, lcg_next(), 4'hf);
		ram_read("null page read", 1'b0, 11'd5);
		csr_write(SYSCTL_BANK, REG_CONTROL, 32'd1);
		model_err_en = 1'b1;
		csr_read("control", SYSCTL_BANK, REG_CONTROL);
		ram_read("null page read with err", 1'b0, 11'd5);
		ram_write("null page write with err", 1'b0, 11'd6, lcg_next(), 4'hf);
		ram_read("null page write took effect", 1'b0, 11'd6);
		ram_read("above null page", 1'b1, words[0]);

		// software hard reset
		csr_write(SYSCTL_BANK, REG_CONTROL, 32'd3);
		clear_model();
		repeat (RST_HOLD_CYCLES + 6) @(posedge sys_clk);
		#1;
		check_value("led after hard reset", 32'd0, {31'd0, led});
		csr_read("control after hard reset", SYSCTL_BANK, REG_CONTROL);

		// three-button chord
		csr_write(SYSCTL_BANK, REG_GPIO_OUT, 32'd1);
		csr_write(SYSCTL_BANK, REG_CONTROL, 32'd1);
		btn = 3'b111;
		repeat (2) @(posedge sys_clk);
		#1;
		btn = 3'b000;
		model_btn = 3'b000;
		clear_model();
		repeat (RST_HOLD_CYCLES + 6) @(posedge sys_clk);
		#1;
		check_value("led after chord", 32'd0, {31'd0, led});
		check_value("irq after chord", 32'd0, {31'd0, irq});
		csr_read("control after chord", SYSCTL_BANK, REG_CONTROL);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- src/soc_top.sv
// soc bus backbone top level
// single wishbone master port, block ram, csr bridge and system controller
// reset comes from trigger_reset, the button chord or a software request

`timescale 1ns/100ps

module soc_top
	import soc_pkg::*;
(
	input  logic                 sys_clk,
	input  logic                 trigger_reset,
	input  logic [WB_ADDR_W-1:0] wb_adr_i,
	input  logic [WB_DATA_W-1:0] wb_dat_i,
	input  logic [WB_SEL_W-1:0]  wb_sel_i,
	input  logic                 wb_we_i,
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	output logic [WB_DATA_W-1:0] wb_dat_o,
	output logic                 wb_ack_o,
	output logic                 wb_err_o,
	input  logic [N_BUTTONS-1:0] btn_i,
	output logic                 led_o,
	output logic                 irq_o
);

	logic                 sys_rst;
	logic                 hard_reset;
	logic                 bus_err_en;
	logic                 ram_stb;
	logic                 csr_stb;
	logic                 sel_csr;
	logic                 unmapped_ack;
	logic                 null_hit;
	logic [WB_DATA_W-1:0] ram_dat;
	logic                 ram_ack;
	logic [WB_DATA_W-1:0] csr_dat;
	logic                 csr_ack;
	logic [CSR_ADR_W-1:0] csr_adr;
	logic                 csr_we;
	logic [WB_DATA_W-1:0] csr_dw;
	logic [WB_DATA_W-1:0] csr_dr;

	// ------------------------------
	// reset
	// ------------------------------
	soc_reset_gen u_reset_gen (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.hard_reset_i  (hard_reset),
		.btn_i         (btn_i),
		.sys_rst_o     (sys_rst)
	);

	// decode stage
	wb_addr_decode u_decode (
		.sys_clk        (sys_clk),
		.sys_rst_i      (sys_rst),
		.wb_adr_i       (wb_adr_i),
		.wb_cyc_i       (wb_cyc_i),
		.wb_stb_i       (wb_stb_i),
		.ram_stb_o      (ram_stb),
		.csr_stb_o      (csr_stb),
		.sel_csr_o      (sel_csr),
		.unmapped_ack_o (unmapped_ack),
		.null_hit_o     (null_hit)
	);

	// ------------------------------
	// slaves
	// ------------------------------
	wb_bram u_bram (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst),
		.stb_i     (ram_stb),
		.we_i      (wb_we_i),
		.adr_i     (wb_adr_i),
		.sel_i     (wb_sel_i),
		.dat_i     (wb_dat_i),
		.dat_o     (ram_dat),
		.ack_o     (ram_ack)
	);

	// byte selects not used by csr, word access only
	wb_csr_bridge u_csr_bridge (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst),
		.stb_i     (csr_stb),
		.we_i      (wb_we_i),
		.adr_i     (wb_adr_i),
		.dat_i     (wb_dat_i),
		.dat_o     (csr_dat),
		.ack_o     (csr_ack),
		.csr_adr_o (csr_adr),
		.csr_we_o  (csr_we),
		.csr_dw_o  (csr_dw),
		.csr_dr_i  (csr_dr)
	);

	sysctl_csr u_sysctl (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst),
		.csr_adr_i    (csr_adr),
		.csr_we_i     (csr_we),
		.csr_dw_i     (csr_dw),
		.csr_dr_o     (csr_dr),
		.btn_i        (btn_i),
		.led_o        (led_o),
		.irq_o        (irq_o),
		.bus_err_en_o (bus_err_en),
		.hard_reset_o (hard_reset)
	);

	// result stage
	wb_response_mux u_resp_mux (
		.sel_csr_i      (sel_csr),
		.ram_dat_i      (ram_dat),
		.ram_ack_i      (ram_ack),
		.csr_dat_i      (csr_dat),
		.csr_ack_i      (csr_ack),
		.unmapped_ack_i (unmapped_ack),
		.null_hit_i     (null_hit),
		.bus_err_en_i   (bus_err_en),
		.wb_dat_o       (wb_dat_o),
		.wb_ack_o       (wb_ack_o),
		.wb_err_o       (wb_err_o)
	);

endmodule

//--- src/wb_response_mux.sv
// response stage back to the bus master
// picks read data, merges acks, qualifies bus errors
// purely combinational, adds no latency

`timescale 1ns/100ps

module wb_response_mux
	import soc_pkg::*;
(
	input  logic                 sel_csr_i,
	input  logic [WB_DATA_W-1:0] ram_dat_i,
	input  logic                 ram_ack_i,
	input  logic [WB_DATA_W-1:0] csr_dat_i,
	input  logic                 csr_ack_i,
	input  logic                 unmapped_ack_i,
	input  logic                 null_hit_i,
	input  logic                 bus_err_en_i,
	output logic [WB_DATA_W-1:0] wb_dat_o,
	output logic                 wb_ack_o,
	output logic                 wb_err_o
);

	logic null_err;

	// unmapped reads return whatever the ram drives
	assign wb_dat_o = sel_csr_i ? csr_dat_i : ram_dat_i;

	// only one slave acks at a time
	assign wb_ack_o = ram_ack_i | csr_ack_i | unmapped_ack_i;

	// null page err only when enabled
	// the ram access itself is not blocked
	assign null_err = bus_err_en_i & null_hit_i & ram_ack_i;

	// err rides with ack
	assign wb_err_o = unmapped_ack_i | null_err;

endmodule

//--- src/sysctl_csr.sv
// system controller csr bank
// gpio buttons and led, button-change irq, bus-error enable,
// software hard reset, capabilities and system id words
// answers bank SYSCTL_BANK only, other banks read zero

`timescale 1ns/100ps

module sysctl_csr
	import soc_pkg::*;
(
	input  logic                 sys_clk,
	input  logic                 sys_rst_i,
	input  logic [CSR_ADR_W-1:0] csr_adr_i,
	input  logic                 csr_we_i,
	input  logic [WB_DATA_W-1:0] csr_dw_i,
	output logic [WB_DATA_W-1:0] csr_dr_o,
	input  logic [N_BUTTONS-1:0] btn_i,
	output logic                 led_o,
	output logic                 irq_o,
	output logic                 bus_err_en_o,
	output logic                 hard_reset_o
);

	logic [CSR_BANK_W-1:0] bank;
	logic [CSR_REG_W-1:0]  idx;
	logic                  bank_hit;
	logic                  wr_gpio_out;
	logic                  wr_irq;
	logic                  wr_ctrl;
	logic [N_BUTTONS-1:0]  btn_meta;
	logic [N_BUTTONS-1:0]  btn_sync;
	logic [N_BUTTONS-1:0]  btn_last;
	logic [N_BUTTONS-1:0]  btn_change;
	logic [N_BUTTONS-1:0]  irq_pending;
	logic [N_BUTTONS-1:0]  irq_clear;
	logic [WB_DATA_W-1:0]  ctrl_word;

	// ------------------------------
	// address decode
	// ------------------------------
	assign bank = csr_adr_i[CSR_ADR_W-1 -: CSR_BANK_W];
	assign idx = csr_adr_i[CSR_REG_W-1:0];
	assign bank_hit = bank == SYSCTL_BANK;

	assign wr_gpio_out = csr_we_i & bank_hit & (idx == REG_GPIO_OUT);
	assign wr_irq = csr_we_i & bank_hit & (idx == REG_IRQ_PENDING);
	assign wr_ctrl = csr_we_i & bank_hit & (idx == REG_CONTROL);

	// two-flop sync, third flop for edge detect
	always_ff @(posedge sys_clk) begin
		btn_meta <= btn_i;
		btn_sync <= btn_meta;
		btn_last <= btn_sync;
	end

	assign btn_change = btn_sync ^ btn_last;
	// write one to clear
	assign irq_clear = wr_irq ? csr_dw_i[N_BUTTONS-1:0] : '0;

	// ------------------------------
	// registers
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			led_o <= 1'b0;
			bus_err_en_o <= 1'b0;
			hard_reset_o <= 1'b0;
			irq_pending <= '0;
		end else begin
			if (wr_gpio_out) begin
				led_o <= csr_dw_i[0];
			end
			if (wr_ctrl) begin
				bus_err_en_o <= csr_dw_i[CTRL_BUS_ERR_EN_BIT];
			end
			// self-clearing, one cycle per write
			hard_reset_o <= wr_ctrl & csr_dw_i[CTRL_HARD_RESET_BIT];
			// a new change wins over a clear in the same cycle
			irq_pending <= (irq_pending & ~irq_clear) | btn_change;
		end
	end

	assign irq_o = |irq_pending;

	// hard reset bit always reads zero
	always_comb begin
		ctrl_word = '0;
		ctrl_word[CTRL_BUS_ERR_EN_BIT] = bus_err_en_o;
	end

	// registered read mux, one cycle after the address
	always_ff @(posedge sys_clk) begin
		csr_dr_o <= '0;
		if (bank_hit) begin
			case (idx)
				REG_GPIO_IN: csr_dr_o <= WB_DATA_W'(btn_sync);
				REG_GPIO_OUT: csr_dr_o <= WB_DATA_W'(led_o);
				REG_IRQ_PENDING: csr_dr_o <= WB_DATA_W'(irq_pending);
				REG_CONTROL: csr_dr_o <= ctrl_word;
				REG_CAPABILITIES: csr_dr_o <= SYSCTL_CAPABILITIES;
				REG_SYSTEM_ID: csr_dr_o <= SYSCTL_SYSTEM_ID;
				default: csr_dr_o <= '0;
			endcase
		end
	end

endmodule

//--- src/wb_csr_bridge.sv
// wishbone to csr bridge
// writes ack after 2 cycles, reads after 3
// csr slaves register their read data one cycle after the address

`timescale 1ns/100ps

module wb_csr_bridge
	import soc_pkg::*;
(
	input  logic                 sys_clk,
	input  logic                 sys_rst_i,
	input  logic                 stb_i,
	input  logic                 we_i,
	input  wb_addr_t             adr_i,
	input  logic [WB_DATA_W-1:0] dat_i,
	output logic [WB_DATA_W-1:0] dat_o,
	output logic                 ack_o,
	output logic [CSR_ADR_W-1:0] csr_adr_o,
	output logic                 csr_we_o,
	output logic [WB_DATA_W-1:0] csr_dw_o,
	input  logic [WB_DATA_W-1:0] csr_dr_i
);

	logic [BRG_ST_W-1:0] state;
	logic                start;

	assign start = (state == BRG_IDLE) & stb_i;

	// ------------------------------
	// control fsm
	// ------------------------------
	// idle -> ack -> done for writes
	// idle -> read -> ack -> done for reads
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= BRG_IDLE;
			ack_o <= 1'b0;
			csr_we_o <= 1'b0;
		end else begin
			// strobes default low
			csr_we_o <= 1'b0;
			ack_o <= 1'b0;
			case (state)
				BRG_IDLE: begin
					if (stb_i) begin
						csr_we_o <= we_i;
						state <= we_i ? BRG_ACK : BRG_READ;
					end
				end
				// slave is registering csr_dr
				BRG_READ: state <= BRG_ACK;
				BRG_ACK: begin
					ack_o <= 1'b1;
					state <= BRG_DONE;
				end
				// stb still high while master sees ack
				default: state <= BRG_IDLE;
			endcase
		end
	end

	// ------------------------------
	// address and data path
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (start) begin
			csr_adr_o <= {adr_i.csr.bank, adr_i.csr.idx};
			csr_dw_o <= dat_i;
		end
		// read data valid by now, writes ignore it
		if (state == BRG_ACK) begin
			dat_o <= csr_dr_i;
		end
	end

	a_we_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		csr_we_o |=> !csr_we_o);

endmodule

//--- src/wb_bram.sv
// on-chip block ram, wishbone slave
// one word per address, byte lanes written under sel_i
// ack comes one cycle after stb, once per request

`timescale 1ns/100ps

module wb_bram
	import soc_pkg::*;
(
	input  logic                 sys_clk,
	input  logic                 sys_rst_i,
	input  logic                 stb_i,
	input  logic                 we_i,
	input  wb_addr_t             adr_i,
	input  logic [WB_SEL_W-1:0]  sel_i,
	input  logic [WB_DATA_W-1:0] dat_i,
	output logic [WB_DATA_W-1:0] dat_o,
	output logic                 ack_o
);

	logic [WB_DATA_W-1:0] mem [2**RAM_ADDR_W];
	logic                 wr_en;

	// skip the ack cycle, stb is still up there
	assign wr_en = stb_i & we_i & ~ack_o;

	// byte-lane write, read back the old word
	always_ff @(posedge sys_clk) begin
		if (wr_en) begin
			for (int i = 0; i < WB_SEL_W; i++) begin
				if (sel_i[i]) begin
					mem[adr_i.ram.word][8*i +: 8] <= dat_i[8*i +: 8];
				end
			end
		end
		dat_o <= mem[adr_i.ram.word];
	end

	// single-cycle ack
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= stb_i & ~ack_o;
		end
	end

endmodule

//--- src/wb_addr_decode.sv
// wishbone address decoder, the decode stage of the bus
// routes stb to the ram or the csr bridge from adr[30:28]
// acks unmapped regions itself and flags null-page ram hits

`timescale 1ns/100ps

module wb_addr_decode
	import soc_pkg::*;
(
	input  logic     sys_clk,
	input  logic     sys_rst_i,
	input  wb_addr_t wb_adr_i,
	input  logic     wb_cyc_i,
	input  logic     wb_stb_i,
	output logic     ram_stb_o,
	output logic     csr_stb_o,
	output logic     sel_csr_o,
	output logic     unmapped_ack_o,
	output logic     null_hit_o
);

	logic req;
	logic hit_ram;
	logic hit_csr;
	logic in_null_page;

	assign req = wb_cyc_i & wb_stb_i;

	// ------------------------------
	// region match
	// ------------------------------
	// msb not looked at, so 0x8xxxxxxx shadows 0x0xxxxxxx
	assign hit_ram = wb_adr_i.ram.region == REGION_RAM;
	// csr owns regions 6 and 7
	assign hit_csr = wb_adr_i.csr.region[REGION_W-1:1] == REGION_CSR[REGION_W-1:1];

	assign ram_stb_o = req & hit_ram;
	assign csr_stb_o = req & hit_csr;
	// steers the read data, master holds adr until ack
	assign sel_csr_o = hit_csr;

	// first 1024 words, no alias bits set
	assign in_null_page = (wb_adr_i.ram.unused == '0)
		&& (wb_adr_i.ram.word[RAM_ADDR_W-1:NULL_PAGE_W] == '0);

	// ------------------------------
	// unmapped ack and null flag
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			unmapped_ack_o <= 1'b0;
			null_hit_o <= 1'b0;
		end else begin
			// one ack per request, stb still high in the ack cycle
			unmapped_ack_o <= req & ~hit_ram & ~hit_csr & ~unmapped_ack_o;
			// lines up with the ram ack one cycle later
			null_hit_o <= ram_stb_o & in_null_page;
		end
	end

	// address must not move while one request is open
	a_adr_stable: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		req && $past(req) |-> $stable(wb_adr_i));

endmodule

//--- src/soc_reset_gen.sv
// system reset generator
// external trigger, software hard reset or the three-button chord
// each reload a hold counter; sys_rst_o stays up while it runs

`timescale 1ns/100ps

module soc_reset_gen
	import soc_pkg::*;
(
	input  logic                 sys_clk,
	input  logic                 trigger_reset,
	input  logic                 hard_reset_i,
	input  logic [N_BUTTONS-1:0] btn_i,
	output logic                 sys_rst_o
);

	logic                 trig_q;
	logic [RST_CNT_W-1:0] hold_cnt;

	// merge all sources, one flop
	// chord only when every button is down
	always_ff @(posedge sys_clk) begin
		trig_q <= trigger_reset | hard_reset_i | (&btn_i);
	end

	// reload on any trigger, else count down to zero
	always_ff @(posedge sys_clk) begin
		if (trig_q) begin
			hold_cnt <= RST_CNT_W'(RST_HOLD_CYCLES);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// trig_q covers the cycle before the reload lands
	assign sys_rst_o = trig_q | (hold_cnt != '0);

	// release only after a full hold window since the last trigger
	a_rst_hold: assert property (@(posedge sys_clk)
		$fell(sys_rst_o) |-> $past(trig_q, RST_HOLD_CYCLES + 1));

endmodule

//--- src/soc_pkg.sv
// shared constants for the bus backbone
// region codes, bus widths, csr register map and the address word views
// import with soc_pkg::* in the module header

package soc_pkg;

	// ------------------------------
	// bus widths
	// ------------------------------
	localparam int WB_ADDR_W = 32;
	localparam int WB_DATA_W = 32;
	localparam int WB_SEL_W = 4;
	localparam int BYTE_LANE_W = 2;

	// region field sits in adr[30:28], bit 31 ignored
	localparam int REGION_W = 3;
	localparam logic [REGION_W-1:0] REGION_RAM = 3'd0;
	// csr matched on the top two region bits, 6 and 7
	localparam logic [REGION_W-1:0] REGION_CSR = 3'd6;

	// block ram, 2048 words
	localparam int RAM_ADDR_W = 11;
	// null page is the first 1024 words
	localparam int NULL_PAGE_W = 10;
	localparam int RAM_PAD_W = WB_ADDR_W - 1 - REGION_W - RAM_ADDR_W - BYTE_LANE_W;

	// ------------------------------
	// csr bus
	// ------------------------------
	localparam int CSR_BANK_W = 4;
	localparam int CSR_REG_W = 8;
	localparam int CSR_ADR_W = CSR_BANK_W + CSR_REG_W;
	localparam int CSR_PAD_W = WB_ADDR_W - 1 - REGION_W - CSR_ADR_W - BYTE_LANE_W;
	localparam logic [CSR_BANK_W-1:0] SYSCTL_BANK = 4'd1;

	// bridge fsm states
	localparam int BRG_ST_W = 2;
	localparam logic [BRG_ST_W-1:0] BRG_IDLE = 2'd0;
	localparam logic [BRG_ST_W-1:0] BRG_READ = 2'd1;
	localparam logic [BRG_ST_W-1:0] BRG_ACK = 2'd2;
	localparam logic [BRG_ST_W-1:0] BRG_DONE = 2'd3;

	// reset hold after the last trigger
	localparam int RST_HOLD_CYCLES = 16;
	localparam int RST_CNT_W = $clog2(RST_HOLD_CYCLES + 1);

	// ------------------------------
	// system controller map
	// ------------------------------
	localparam logic [WB_DATA_W-1:0] SYSCTL_SYSTEM_ID = 32'h534F_4331;
	// bit 0 bram, bit 1 bus errors, bit 2 gpio irq
	localparam logic [WB_DATA_W-1:0] SYSCTL_CAPABILITIES = 32'h0000_0007;
	localparam logic [CSR_REG_W-1:0] REG_GPIO_IN = 8'd0;
	localparam logic [CSR_REG_W-1:0] REG_GPIO_OUT = 8'd1;
	localparam logic [CSR_REG_W-1:0] REG_IRQ_PENDING = 8'd2;
	localparam logic [CSR_REG_W-1:0] REG_CONTROL = 8'd3;
	localparam logic [CSR_REG_W-1:0] REG_CAPABILITIES = 8'd4;
	localparam logic [CSR_REG_W-1:0] REG_SYSTEM_ID = 8'd5;
	localparam int CTRL_BUS_ERR_EN_BIT = 0;
	localparam int CTRL_HARD_RESET_BIT = 1;
	localparam int N_BUTTONS = 3;

	// one address word, read as a ram or a csr access
	typedef union packed {
		struct packed {
			logic msb;
			logic [REGION_W-1:0] region;
			logic [RAM_PAD_W-1:0] unused;
			logic [RAM_ADDR_W-1:0] word;
			logic [BYTE_LANE_W-1:0] lane;
		} ram;
		struct packed {
			logic msb;
			logic [REGION_W-1:0] region;
			logic [CSR_PAD_W-1:0] unused;
			logic [CSR_BANK_W-1:0] bank;
			logic [CSR_REG_W-1:0] idx;
			logic [BYTE_LANE_W-1:0] lane;
		} csr;
	} wb_addr_t;

endpackage
